/* include/prn_config.svh */
/* Constants for the ranging-code generator. Included by the package,
   the RTL and the testbench. */
`ifndef PRN_CONFIG_SVH
`define PRN_CONFIG_SVH

// ----------------------------------------
// Gold code shift registers
// ----------------------------------------
`define PRN_G_LEN        10                  // stages per register
// stage n sits at bit n-1, stage 10 is the output
`define PRN_G1_TAPS      10'h204             // stages 3 and 10
`define PRN_G2_TAPS      10'h3a6             // stages 2,3,6,8,9,10
`define PRN_GOLD_PERIOD  1023                // chips per period

// ----------------------------------------
// satellite range
// ----------------------------------------
`define PRN_SVID_W       6
`define PRN_SVID_MAX     32                  // last id with a Gold entry

// ----------------------------------------
// memory code ROM geometry
// ----------------------------------------
`define PRN_MEM_ADDR_W   14
`define PRN_MEM_DATA_W   32
`define PRN_MEM_WORDS    4                   // words per satellite block
`define PRN_MEM_BASE     49                  // block index offset

`endif

/* source/prn_pkg.sv */
/* Shared types of the ranging-code generator, imported by the RTL
   and the testbench. */
`include "prn_config.svh"

package prn_pkg;

	// ----------------------------------------
	// register, id and ROM word types
	// ----------------------------------------
	typedef logic [`PRN_G_LEN-1:0]      g_state_t;   // [9] is stage 10
	typedef logic [`PRN_SVID_W-1:0]     svid_t;
	typedef logic [`PRN_MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [`PRN_MEM_DATA_W-1:0] mem_word_t;

	// which engine serves phase-init and shift
	typedef enum logic {
		FAMILY_GOLD    = 1'b0,
		FAMILY_MEMCODE = 1'b1
	} code_family_t;

endpackage

/* source/gold_init_table.sv */
/* Initial G2 state per satellite, derived from the published first
   ten chips. Pure combinational lookup. */
`timescale 1ns/10ps
`include "prn_config.svh"

module gold_init_table
	import prn_pkg::*;
(
	input  svid_t    svid_i,
	output g_state_t g2_init_o
);

	logic [`PRN_G_LEN-1:0] first_chips;	// first 10 chips, first chip in MSB

	// G1 starts at all ones, so the first ten chips are the inverted
	// G2 stages read from stage 10 down to stage 1
	always_comb begin
		case (svid_i)
			6'd1 : first_chips = 10'o1440;
			6'd2 : first_chips = 10'o1620;
			6'd3 : first_chips = 10'o1710;
			6'd4 : first_chips = 10'o1744;
			6'd5 : first_chips = 10'o1133;
			6'd6 : first_chips = 10'o1455;
			6'd7 : first_chips = 10'o1131;
			6'd8 : first_chips = 10'o1454;
			6'd9 : first_chips = 10'o1626;
			6'd10: first_chips = 10'o1504;
			6'd11: first_chips = 10'o1642;
			6'd12: first_chips = 10'o1750;
			6'd13: first_chips = 10'o1764;
			6'd14: first_chips = 10'o1772;
			6'd15: first_chips = 10'o1775;
			6'd16: first_chips = 10'o1776;
			6'd17: first_chips = 10'o1156;
			6'd18: first_chips = 10'o1467;
			6'd19: first_chips = 10'o1633;
			6'd20: first_chips = 10'o1715;
			6'd21: first_chips = 10'o1746;
			6'd22: first_chips = 10'o1763;
			6'd23: first_chips = 10'o1063;
			6'd24: first_chips = 10'o1706;
			6'd25: first_chips = 10'o1743;
			6'd26: first_chips = 10'o1761;
			6'd27: first_chips = 10'o1770;
			6'd28: first_chips = 10'o1774;
			6'd29: first_chips = 10'o1127;
			6'd30: first_chips = 10'o1453;
			6'd31: first_chips = 10'o1625;
			6'd32: first_chips = 10'o1712;	// last entry, PRN_SVID_MAX
			default: first_chips = '1;	// inverts to an all-zero state
		endcase
	end

	assign g2_init_o = ~first_chips;

endmodule

/* source/gold_code_gen.sv */
/* Gold code engine. G1/G2 registers with fixed taps, loaded on
   phase-init and reloaded every 1023 chips. */
`timescale 1ns/10ps
`include "prn_config.svh"

module gold_code_gen
	import prn_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     phase_init_i,
	input  logic     shift_code_i,
	input  g_state_t g2_init_i,
	output logic     prn_code_o
);

	localparam int CNT_W = $clog2(`PRN_GOLD_PERIOD);
	localparam logic [CNT_W-1:0] LAST_CHIP = CNT_W'(`PRN_GOLD_PERIOD - 1);

	g_state_t         g1_q;
	g_state_t         g2_q;
	g_state_t         g2_seed;	// G2 start state of this run
	logic [CNT_W-1:0] chip_cnt;
	logic             g1_fb;
	logic             g2_fb;
	logic             period_end;

	// ----------------------------------------
	// feedback and period detect
	// ----------------------------------------
	assign g1_fb      = ^(g1_q & `PRN_G1_TAPS);
	assign g2_fb      = ^(g2_q & `PRN_G2_TAPS);
	assign period_end = (chip_cnt == LAST_CHIP);

	always_ff @(posedge clk) begin
		if (phase_init_i)
			g2_seed <= g2_init_i;
	end

	// ----------------------------------------
	// shift registers and chip counter
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			g1_q     <= '0;
			g2_q     <= '0;
			chip_cnt <= '0;
		end else if (phase_init_i) begin
			g1_q     <= '1;
			g2_q     <= g2_init_i;
			chip_cnt <= '0;
		end else if (shift_code_i) begin
			if (period_end) begin	// restart the code
				g1_q     <= '1;
				g2_q     <= g2_seed;
				chip_cnt <= '0;
			end else begin
				g1_q     <= {g1_q[`PRN_G_LEN-2:0], g1_fb};
				g2_q     <= {g2_q[`PRN_G_LEN-2:0], g2_fb};
				chip_cnt <= chip_cnt + 1'b1;
			end
		end
	end

	// chip is the XOR of both stage-10 outputs
	assign prn_code_o = g1_q[`PRN_G_LEN-1] ^ g2_q[`PRN_G_LEN-1];

endmodule

/* source/memcode_fetch.sv */
/* Memory code engine. Fetches the satellite's ROM block through the
   rd/valid handshake with a one-word prefetch and shifts chips MSB first. */
`timescale 1ns/10ps
`include "prn_config.svh"

module memcode_fetch
	import prn_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      phase_init_i,
	input  logic      shift_code_i,
	input  svid_t     svid_i,
	output mem_addr_t memcode_addr_o,
	output logic      memcode_rd_o,
	input  logic      memcode_read_valid_i,
	input  mem_word_t memcode_data_i,
	output logic      ready_to_shift_o,
	output logic      prn_code_o
);

	localparam int BIT_W = $clog2(`PRN_MEM_DATA_W);
	localparam int IDX_W = $clog2(`PRN_MEM_WORDS);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`PRN_MEM_DATA_W - 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`PRN_MEM_WORDS - 1);

	mem_addr_t        start_addr;
	mem_addr_t        base_addr;	// block start of this run
	logic [IDX_W-1:0] word_idx;	// next word to fetch
	logic             active;
	logic             drop;
	logic             capture;
	logic             fetch_start;
	mem_word_t        cur_word;
	mem_word_t        buf_word;
	logic             cur_valid;
	logic             buf_valid;
	logic [BIT_W-1:0] bit_cnt;
	logic             shift_ok;
	logic             word_done;
	logic             load_cur;
	logic             load_buf;

	assign start_addr = mem_addr_t'((`PRN_MEM_BASE + svid_i) * `PRN_MEM_WORDS);

	// ----------------------------------------
	// ROM request / valid handshake
	// ----------------------------------------
	assign capture     = memcode_rd_o & memcode_read_valid_i & ~drop & ~phase_init_i;
	assign fetch_start = active & ~memcode_rd_o & ~buf_valid & ~phase_init_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			active         <= 1'b0;
			memcode_rd_o   <= 1'b0;
			memcode_addr_o <= '0;
			drop           <= 1'b0;
			base_addr      <= '0;
			word_idx       <= '0;
		end else begin
			if (phase_init_i) begin
				active    <= 1'b1;
				base_addr <= start_addr;
				word_idx  <= '0;
			end else if (capture) begin
				word_idx <= (word_idx == LAST_IDX) ? '0 : word_idx + 1'b1;	// wrap in block
			end

			if (memcode_rd_o && memcode_read_valid_i) begin
				memcode_rd_o <= 1'b0;
				drop         <= 1'b0;
			end else if (memcode_rd_o && phase_init_i) begin
				drop <= 1'b1;	// stale read still has to complete
			end else if (fetch_start) begin
				memcode_rd_o   <= 1'b1;
				memcode_addr_o <= base_addr + mem_addr_t'(word_idx);	// held until valid
			end
		end
	end

	// ----------------------------------------
	// current word, prefetch buffer, bit count
	// ----------------------------------------
	assign shift_ok  = shift_code_i & cur_valid;	// back-pressure when empty
	assign word_done = shift_ok & (bit_cnt == LAST_BIT);
	assign load_cur  = capture & (~cur_valid | word_done);
	assign load_buf  = capture & ~load_cur;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cur_valid <= 1'b0;
			buf_valid <= 1'b0;
			bit_cnt   <= '0;
		end else if (phase_init_i) begin
			cur_valid <= 1'b0;
			buf_valid <= 1'b0;
			bit_cnt   <= '0;
		end else begin
			if (load_cur || (word_done && buf_valid))
				cur_valid <= 1'b1;
			else if (word_done)
				cur_valid <= 1'b0;	// starved, wait for the ROM

			if (load_buf)
				buf_valid <= 1'b1;
			else if (word_done)
				buf_valid <= 1'b0;	// moved into the current word

			if (word_done)
				bit_cnt <= '0;
			else if (shift_ok)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (word_done && buf_valid)
			cur_word <= buf_word;
		else if (load_cur)
			cur_word <= memcode_data_i;
		else if (shift_ok)
			cur_word <= {cur_word[`PRN_MEM_DATA_W-2:0], 1'b0};

		if (load_buf)
			buf_word <= memcode_data_i;
	end

	assign ready_to_shift_o = cur_valid;
	assign prn_code_o       = cur_valid & cur_word[`PRN_MEM_DATA_W-1];

endmodule

/* source/prn_gen_top.sv */
/* Top level of the ranging-code generator. Steers the controls to the
   selected engine and muxes its chip and ready flag back out. */
`timescale 1ns/10ps
`include "prn_config.svh"

module prn_gen_top
	import prn_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n_i,
	input  code_family_t family_i,
	input  svid_t        svid_i,
	input  logic         phase_init_i,
	input  logic         shift_code_i,
	output logic         ready_to_shift_o,
	output logic         prn_code_o,
	output mem_addr_t    memcode_addr_o,
	output logic         memcode_rd_o,
	input  logic         memcode_read_valid_i,
	input  mem_word_t    memcode_data_i
);

	logic     gold_sel;
	logic     gold_phase_init;
	logic     gold_shift;
	logic     mem_phase_init;
	logic     mem_shift;
	g_state_t g2_init;
	logic     gold_chip;
	logic     mem_chip;
	logic     mem_ready;

	// ----------------------------------------
	// control steering
	// ----------------------------------------
	assign gold_sel        = (family_i == FAMILY_GOLD);
	assign gold_phase_init = phase_init_i & gold_sel;
	assign gold_shift      = shift_code_i & gold_sel;
	assign mem_phase_init  = phase_init_i & ~gold_sel;
	assign mem_shift       = shift_code_i & ~gold_sel;

	gold_init_table u_gold_table (
		.svid_i    (svid_i),
		.g2_init_o (g2_init)
	);

	gold_code_gen u_gold_gen (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.phase_init_i (gold_phase_init),
		.shift_code_i (gold_shift),
		.g2_init_i    (g2_init),
		.prn_code_o   (gold_chip)
	);

	memcode_fetch u_memcode (
		.clk                  (clk),
		.rst_n_i              (rst_n_i),
		.phase_init_i         (mem_phase_init),
		.shift_code_i         (mem_shift),
		.svid_i               (svid_i),
		.memcode_addr_o       (memcode_addr_o),
		.memcode_rd_o         (memcode_rd_o),
		.memcode_read_valid_i (memcode_read_valid_i),
		.memcode_data_i       (memcode_data_i),
		.ready_to_shift_o     (mem_ready),
		.prn_code_o           (mem_chip)
	);

	// output mux, Gold engine never stalls
	assign prn_code_o       = gold_sel ? gold_chip : mem_chip;
	assign ready_to_shift_o = gold_sel ? 1'b1 : mem_ready;

endmodule

/* tb/tb_prn_gen.sv */
/* Testbench for prn_gen_top. Runs a table of Gold and memory-code tests against
   a G1/G2 reference model and a random ROM model with a slow handshake. */
`timescale 1ns/10ps
`include "prn_config.svh"

module tb_prn_gen
	import prn_pkg::*;
;

	localparam int N_TESTS  = 8;
	localparam int ROM_SIZE = 1 << `PRN_MEM_ADDR_W;

	logic         clk;
	logic         rst_n_i;
	code_family_t family_i;
	svid_t        svid_i;
	logic         phase_init_i;
	logic         shift_code_i;
	logic         ready_to_shift_o;
	logic         prn_code_o;
	mem_addr_t    memcode_addr_o;
	logic         memcode_rd_o;
	logic         memcode_read_valid_i = 1'b0;
	mem_word_t    memcode_data_i = '0;

	// stimulus table, one row per test
	string        tc_name   [N_TESTS];
	code_family_t tc_family [N_TESTS];
	svid_t        tc_svid   [N_TESTS];
	int           tc_chips  [N_TESTS];
	logic [9:0]   tc_first  [N_TESTS];	// first 10 chips as octal, Gold only

	mem_word_t    rom [0:ROM_SIZE-1];
	logic         gold_seq [`PRN_GOLD_PERIOD];	// one full reference period
	logic         rom_busy = 1'b0;
	int unsigned  rom_wait = 0;
	bit           mem_started = 1'b0;	// memcode engine has been started
	int           cycle_cnt = 0;
	int           timeout_limit = 0;

	prn_gen_top dut0 (
		.clk                  (clk),
		.rst_n_i              (rst_n_i),
		.family_i             (family_i),
		.svid_i               (svid_i),
		.phase_init_i         (phase_init_i),
		.shift_code_i         (shift_code_i),
		.ready_to_shift_o     (ready_to_shift_o),
		.prn_code_o           (prn_code_o),
		.memcode_addr_o       (memcode_addr_o),
		.memcode_rd_o         (memcode_rd_o),
		.memcode_read_valid_i (memcode_read_valid_i),
		.memcode_data_i       (memcode_data_i)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ----------------------------------------
	// ROM model, 1 to 4 cycles per request
	// ----------------------------------------
	always @(posedge clk) begin
		if (!rst_n_i) begin
			memcode_read_valid_i <= 1'b0;
			rom_busy             <= 1'b0;
			rom_wait             <= 0;
		end else if (memcode_read_valid_i) begin
			memcode_read_valid_i <= 1'b0;	// single valid cycle
			rom_busy             <= 1'b0;
		end else if (rom_busy) begin
			if (rom_wait == 1) begin
				memcode_read_valid_i <= 1'b1;
				memcode_data_i       <= rom[memcode_addr_o];
			end
			rom_wait <= rom_wait - 1;
		end else if (memcode_rd_o) begin
			rom_busy <= 1'b1;
			rom_wait <= $urandom_range(4, 1);
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
			$display("timeout after %0d cycles, the DUT stopped delivering chips", cycle_cnt);
			$display("TEST FAIL");
			$fatal(1, "run aborted on timeout");
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic set_row(input int idx, input string name, input code_family_t fam,
		input int sv, input int chips, input logic [9:0] first);
		tc_name[idx]   = name;
		tc_family[idx] = fam;
		tc_svid[idx]   = svid_t'(sv);
		tc_chips[idx]  = chips;
		tc_first[idx]  = first;
	endtask

	task automatic load_table();
		// one Gold period plus 10 chips shows the repeat
		set_row(0, "gold_sv1",  FAMILY_GOLD,     1,  1033, 10'o1440);
		set_row(1, "gold_sv2",  FAMILY_GOLD,     2,  1033, 10'o1620);
		set_row(2, "gold_sv3",  FAMILY_GOLD,     3,  1033, 10'o1710);
		set_row(3, "gold_sv4",  FAMILY_GOLD,     4,  1033, 10'o1744);
		set_row(4, "gold_sv32", FAMILY_GOLD,     32, 1033, 10'o1712);
		set_row(5, "mem_sv1",   FAMILY_MEMCODE,  1,  256,  10'o0);	// two full blocks
		set_row(6, "mem_sv7",   FAMILY_MEMCODE,  7,  256,  10'o0);
		set_row(7, "mem_sv14",  FAMILY_MEMCODE,  14, 256,  10'o0);
	endtask

	function automatic int timeout_cycles();
		int total;
		int n;
		total = 0;
		for (n = 0; n < N_TESTS; n++)
			total += tc_chips[n];
		return total * 8 + 200;
	endfunction

	// ----------------------------------------
	// reference models
	// ----------------------------------------
	task automatic build_gold_ref(input logic [9:0] first);
		logic [10:1] g1;	// index is the stage number
		logic [10:1] g2;
		logic        fb1;
		logic        fb2;
		int          s;
		int          k;
		g1 = '1;
		// with G1 all ones, chip k is the inverse of G2 stage 10-k
		for (s = 1; s <= 10; s++)
			g2[s] = ~first[s-1];
		for (k = 0; k < `PRN_GOLD_PERIOD; k++) begin
			gold_seq[k] = g1[10] ^ g2[10];
			fb1 = g1[3] ^ g1[10];
			fb2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
			g1  = {g1[9:1], fb1};
			g2  = {g2[9:1], fb2};
		end
	endtask

	function automatic logic memcode_chip(input svid_t sv, input int k);
		int        base;
		int        word;
		mem_word_t data;
		base = (`PRN_MEM_BASE + int'(sv)) * `PRN_MEM_WORDS;
		word = (k / `PRN_MEM_DATA_W) % `PRN_MEM_WORDS;	// wraps inside the block
		data = rom[base + word];
		return data[`PRN_MEM_DATA_W - 1 - (k % `PRN_MEM_DATA_W)];
	endfunction

	// ----------------------------------------
	// one table row
	// ----------------------------------------
	task automatic run_test(input int t);
		int         i;
		int         stall_hits;
		bit         is_gold;
		logic       exp_chip;
		logic       next_shift;
		logic [9:0] first10;
		i          = 0;
		stall_hits = 0;
		first10    = '0;
		is_gold    = (tc_family[t] == FAMILY_GOLD);
		if (is_gold)
			build_gold_ref(tc_first[t]);
		else
			mem_started = 1'b1;

		@(posedge clk);
		family_i     <= tc_family[t];
		svid_i       <= tc_svid[t];
		phase_init_i <= 1'b1;
		shift_code_i <= 1'b0;
		@(posedge clk);
		phase_init_i <= 1'b0;
		shift_code_i <= 1'b1;	// held while the first word is fetched

		while (i < tc_chips[t]) begin
			@(negedge clk);
			if (is_gold) begin
				check_value({tc_name[t], " ready"}, 32'd1, 32'(ready_to_shift_o));
				if (!mem_started)
					check_value({tc_name[t], " rd idle"}, 32'd0, 32'(memcode_rd_o));
				exp_chip = gold_seq[i % `PRN_GOLD_PERIOD];
			end else begin
				exp_chip = memcode_chip(tc_svid[t], i);
			end
			if (ready_to_shift_o) begin
				check_value($sformatf("%s chip %0d", tc_name[t], i), 32'(exp_chip),
					32'(prn_code_o));
				if (shift_code_i) begin	// taken at the next edge
					if (i < 10)
						first10 = {first10[8:0], prn_code_o};
					i++;
					if (is_gold && i == 10)
						check_value({tc_name[t], " first10"}, 32'(tc_first[t]),
							32'(first10));
				end
			end else if (shift_code_i) begin
				stall_hits++;	// must be ignored by the DUT
			end
			next_shift = ready_to_shift_o ? ($urandom_range(3, 0) != 0) : 1'b1;
			@(posedge clk);
			shift_code_i <= next_shift;
		end
		if (!is_gold)
			check_value({tc_name[t], " stalled shifts"}, 32'd1, 32'(stall_hits > 0));
	endtask

	initial begin
		int a;
		int t;
		void'($urandom(22081));
		rst_n_i      = 1'b0;
		family_i     = FAMILY_GOLD;
		svid_i       = '0;
		phase_init_i = 1'b0;
		shift_code_i = 1'b0;
		load_table();
		for (a = 0; a < ROM_SIZE; a++)
			rom[a] = $urandom() ^ 32'(a);
		timeout_limit = timeout_cycles();

		repeat (2) @(posedge clk);
		rst_n_i <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_value("rd low after reset", 32'd0, 32'(memcode_rd_o));
		end

		for (t = 0; t < N_TESTS; t++)
			run_test(t);

		@(posedge clk);
		shift_code_i <= 1'b0;
		$display("TEST PASS");
		$finish;
	end

endmodule

/* prn_gen.f */
+incdir+include
source/prn_pkg.sv
source/gold_init_table.sv
source/gold_code_gen.sv
source/memcode_fetch.sv
source/prn_gen_top.sv
tb/tb_prn_gen.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the PRN generator testbench with Verilator.
# Exits non-zero when the build fails or the simulation reports a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_prn

verilator --binary --timing -Wno-fatal \
	-f prn_gen.f \
	--top-module tb_prn_gen \
	-o "$BIN"
if [ $? -ne 0 ]; then
	echo "run_sim: verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
	echo "run_sim: simulation reported a failure"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "run_sim: simulator exited with status $sim_status"
	exit 1
fi

echo "run_sim: simulation passed"
exit 0
